// File: src/usb_pid_pkg.sv
package usb_pid_pkg;

  // Low two bits of the PID code select the packet group
  localparam logic [1:0] PID_GROUP_HSK  = 2'b10;
  localparam logic [1:0] PID_GROUP_TOK  = 2'b01;
  localparam logic [1:0] PID_GROUP_DATA = 2'b11;

  // Packet kinds, one per requester
  localparam logic [1:0] KIND_HSK  = 2'd0;
  localparam logic [1:0] KIND_TOK  = 2'd1;
  localparam logic [1:0] KIND_DATA = 2'd2;

  // Upper nibble carries the inverse of the code for integrity checking
  typedef struct packed {
    logic [3:0] check;
    logic [3:0] code;
  } pid_nibbles_t;

  // The same PID byte, read raw or as check and code
  typedef union packed {
    logic [7:0]   raw;
    pid_nibbles_t nib;
  } pid_byte_u;

endpackage

// File: src/usb_enc_pkg.sv
package usb_enc_pkg;

  // Encoder sequencing
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PID,
    ST_BODY,
    ST_CRC,
    ST_DONE
  } state_e;

  // USB CRC16, reflected form of 0x8005
  localparam logic [15:0] CRC16_INIT     = 16'hFFFF;
  localparam logic [15:0] CRC16_POLY_REV = 16'hA001;

  // Tail byte counter
  localparam int CNT_W = 2;

  // Token bodies and CRC tails are both two bytes
  localparam logic [CNT_W-1:0] CNT_TAIL = 2'd2;

endpackage

// File: src/tx_byte_counter.sv
`timescale 1ns/10ps

module tx_byte_counter (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          load_i,
  input  logic [usb_enc_pkg::CNT_W-1:0] value_i,
  input  logic                          step_i,
  output logic                          zero_o
);

  logic [usb_enc_pkg::CNT_W-1:0] cnt_q;

  // Load wins over a step in the same cycle
  always_ff @(posedge clock) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (load_i) begin
      cnt_q <= value_i;
    end else if (step_i && !zero_o) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign zero_o = (cnt_q == '0);

  // A new tail is only loaded once the previous one has fully drained
  a_load_after_drain: assert property (@(posedge clock) disable iff (reset)
    load_i |-> zero_o);

endmodule

// File: src/crc16_unit.sv
`timescale 1ns/10ps

module crc16_unit (
  input  logic        clock,
  input  logic        reset,
  input  logic        clear_i,
  input  logic        byte_valid_i,
  input  logic [7:0]  byte_i,
  output logic [15:0] crc_o
);

  logic [15:0] crc_q;
  logic [15:0] crc_next;

  // Eight LSB-first steps of the reflected LFSR
  always_comb begin
    crc_next = crc_q;
    for (int i = 0; i < 8; i++) begin
      if (crc_next[0] ^ byte_i[i]) begin
        crc_next = (crc_next >> 1) ^ usb_enc_pkg::CRC16_POLY_REV;
      end else begin
        crc_next = crc_next >> 1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset || clear_i) begin
      crc_q <= usb_enc_pkg::CRC16_INIT;
    end else if (byte_valid_i) begin
      crc_q <= crc_next;
    end
  end

  // Reflected register already holds the bit-reversed remainder,
  // so only the inversion is left
  assign crc_o = ~crc_q;

endmodule

// File: src/payload_skid.sv
`timescale 1ns/10ps

module payload_skid (
  input  logic       clock,
  input  logic       reset,
  input  logic       enable_i,
  input  logic       in_valid_i,
  input  logic       in_last_i,
  input  logic [7:0] in_data_i,
  input  logic       pop_i,
  output logic       in_ready_o,
  output logic       out_valid_o,
  output logic       out_last_o,
  output logic [7:0] out_data_o,
  output logic       accept_o
);

  logic       h_valid_q;
  logic       h_last_q;
  logic [7:0] h_data_q;
  logic       s_valid_q;
  logic       s_last_q;
  logic [7:0] s_data_q;
  logic       last_seen_q;

  // Ready comes from registers only, spare slot keeps throughput at one per cycle
  assign in_ready_o = enable_i && !s_valid_q && !last_seen_q;
  assign accept_o   = in_valid_i && in_ready_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      h_valid_q   <= 1'b0;
      s_valid_q   <= 1'b0;
      last_seen_q <= 1'b0;
    end else begin
      if (!enable_i) begin
        last_seen_q <= 1'b0;
      end else if (accept_o && in_last_i) begin
        last_seen_q <= 1'b1;
      end

      case ({accept_o, pop_i})
        2'b10: begin
          if (h_valid_q) begin
            s_valid_q <= 1'b1;
          end else begin
            h_valid_q <= 1'b1;
          end
        end
        2'b01: begin
          h_valid_q <= s_valid_q;
          s_valid_q <= 1'b0;
        end
        // Push with pop just replaces the head
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept_o && (!h_valid_q || pop_i)) begin
      h_data_q <= in_data_i;
      h_last_q <= in_last_i;
    end else if (pop_i) begin
      h_data_q <= s_data_q;
      h_last_q <= s_last_q;
    end

    if (accept_o && h_valid_q && !pop_i) begin
      s_data_q <= in_data_i;
      s_last_q <= in_last_i;
    end
  end

  assign out_valid_o = h_valid_q;
  assign out_last_o  = h_last_q;
  assign out_data_o  = h_data_q;

  // The encoder only pops a head that is present
  a_pop_valid: assert property (@(posedge clock) disable iff (reset)
    pop_i |-> h_valid_q);

  // Nothing is queued behind the final payload byte
  a_last_is_tail: assert property (@(posedge clock) disable iff (reset)
    h_valid_q && h_last_q |-> !s_valid_q);

endmodule

// File: src/encode_fsm.sv
`timescale 1ns/10ps

module encode_fsm (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          hsk_send_i,
  input  logic [1:0]                    hsk_type_i,
  input  logic                          tok_send_i,
  input  logic [1:0]                    tok_type_i,
  input  logic [15:0]                   tok_data_i,
  input  logic                          trn_send_i,
  input  logic [1:0]                    trn_type_i,
  input  logic                          trn_tvalid_i,
  input  logic                          trn_tlast_i,
  input  logic                          skid_valid_i,
  input  logic                          skid_last_i,
  input  logic [7:0]                    skid_data_i,
  input  logic [15:0]                   crc_value_i,
  input  logic                          cnt_zero_i,
  input  logic                          tx_tready_i,
  output logic                          body_en_o,
  output logic                          skid_pop_o,
  output logic                          crc_clear_o,
  output logic                          cnt_load_o,
  output logic [usb_enc_pkg::CNT_W-1:0] cnt_value_o,
  output logic                          tx_tvalid_o,
  output logic                          tx_tlast_o,
  output logic [7:0]                    tx_tdata_o,
  output logic                          hsk_done_o,
  output logic                          tok_done_o,
  output logic                          trn_done_o,
  output logic                          enc_busy_o
);

  usb_enc_pkg::state_e    state_q;
  usb_pid_pkg::pid_byte_u pid;
  logic [1:0]  kind_q;
  logic [1:0]  sel_kind;
  logic        zero_len_q;
  logic        zero_len_d;
  logic        hsk_hold_q;
  logic        tok_hold_q;
  logic        trn_hold_q;
  logic        req_any;
  logic        tx_valid_q;
  logic        tx_last_q;
  logic [7:0]  tx_data_q;
  logic        tx_fire;
  logic        tail_state;
  logic        data_body;
  logic [15:0] tail_word;

  // Fixed priority, a requester must drop send before it is served again
  always_comb begin
    req_any       = 1'b1;
    sel_kind      = usb_pid_pkg::KIND_DATA;
    pid.nib.code  = {trn_type_i, usb_pid_pkg::PID_GROUP_DATA};
    if (hsk_send_i && !hsk_hold_q) begin
      sel_kind     = usb_pid_pkg::KIND_HSK;
      pid.nib.code = {hsk_type_i, usb_pid_pkg::PID_GROUP_HSK};
    end else if (tok_send_i && !tok_hold_q) begin
      sel_kind     = usb_pid_pkg::KIND_TOK;
      pid.nib.code = {tok_type_i, usb_pid_pkg::PID_GROUP_TOK};
    end else if (!trn_send_i || trn_hold_q) begin
      req_any = 1'b0;
    end
    pid.nib.check = ~pid.nib.code;
  end

  assign zero_len_d = (sel_kind == usb_pid_pkg::KIND_DATA) && trn_tlast_i && !trn_tvalid_i;
  assign tx_fire    = tx_valid_q && tx_tready_i;
  assign data_body  = (state_q == usb_enc_pkg::ST_BODY) && (kind_q == usb_pid_pkg::KIND_DATA);
  assign tail_state = (state_q == usb_enc_pkg::ST_CRC) ||
                      ((state_q == usb_enc_pkg::ST_BODY) && (kind_q == usb_pid_pkg::KIND_TOK));
  assign tail_word  = (kind_q == usb_pid_pkg::KIND_TOK) ? tok_data_i : crc_value_i;

  assign body_en_o   = data_body;
  // Cleared in idle too so an empty packet sends the inverted start value
  assign crc_clear_o = (state_q == usb_enc_pkg::ST_IDLE) || (state_q == usb_enc_pkg::ST_PID);
  // Counter is zero in the body until the last payload byte is taken
  assign skid_pop_o  = data_body && cnt_zero_i && skid_valid_i && (!tx_valid_q || tx_tready_i);

  // Tokens and empty data packets know their tail at acceptance
  assign cnt_load_o  = ((state_q == usb_enc_pkg::ST_IDLE) && req_any &&
                        ((sel_kind == usb_pid_pkg::KIND_TOK) || zero_len_d)) ||
                       (skid_pop_o && skid_last_i);
  assign cnt_value_o = usb_enc_pkg::CNT_TAIL;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q    <= usb_enc_pkg::ST_IDLE;
      kind_q     <= usb_pid_pkg::KIND_HSK;
      zero_len_q <= 1'b0;
      tx_valid_q <= 1'b0;
      tx_last_q  <= 1'b0;
      hsk_hold_q <= 1'b0;
      tok_hold_q <= 1'b0;
      trn_hold_q <= 1'b0;
    end else begin
      hsk_hold_q <= hsk_send_i && (hsk_hold_q || hsk_done_o);
      tok_hold_q <= tok_send_i && (tok_hold_q || tok_done_o);
      trn_hold_q <= trn_send_i && (trn_hold_q || trn_done_o);

      case (state_q)
        usb_enc_pkg::ST_IDLE: begin
          if (req_any) begin
            state_q    <= usb_enc_pkg::ST_PID;
            kind_q     <= sel_kind;
            zero_len_q <= zero_len_d;
            tx_valid_q <= 1'b1;
            tx_last_q  <= (sel_kind == usb_pid_pkg::KIND_HSK);
          end
        end
        usb_enc_pkg::ST_PID: begin
          if (tx_fire) begin
            if (kind_q == usb_pid_pkg::KIND_HSK) begin
              state_q    <= usb_enc_pkg::ST_DONE;
              tx_valid_q <= 1'b0;
              tx_last_q  <= 1'b0;
            end else if (kind_q == usb_pid_pkg::KIND_TOK) begin
              state_q <= usb_enc_pkg::ST_BODY;
            end else if (zero_len_q) begin
              state_q <= usb_enc_pkg::ST_CRC;
            end else begin
              state_q    <= usb_enc_pkg::ST_BODY;
              tx_valid_q <= 1'b0;
            end
          end
        end
        usb_enc_pkg::ST_BODY, usb_enc_pkg::ST_CRC: begin
          if (tail_state) begin
            // Low tail byte leaves with the count at one, high byte at zero
            if (tx_fire && cnt_zero_i) begin
              state_q    <= usb_enc_pkg::ST_DONE;
              tx_valid_q <= 1'b0;
              tx_last_q  <= 1'b0;
            end else if (tx_fire) begin
              tx_last_q <= 1'b1;
            end
          end else if (tx_fire && !cnt_zero_i) begin
            state_q <= usb_enc_pkg::ST_CRC;
          end else if (skid_pop_o) begin
            tx_valid_q <= 1'b1;
          end else if (tx_fire) begin
            // Payload starved, hold the packet open
            tx_valid_q <= 1'b0;
          end
        end
        default: begin
          state_q <= usb_enc_pkg::ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state_q == usb_enc_pkg::ST_IDLE) begin
      tx_data_q <= pid.raw;
    end else if (skid_pop_o) begin
      tx_data_q <= skid_data_i;
    end else if (tx_fire) begin
      tx_data_q <= tail_state ? tail_word[15:8] : tail_word[7:0];
    end
  end

  assign tx_tvalid_o = tx_valid_q;
  assign tx_tlast_o  = tx_last_q;
  assign tx_tdata_o  = tx_data_q;

  assign hsk_done_o = (state_q == usb_enc_pkg::ST_DONE) && (kind_q == usb_pid_pkg::KIND_HSK);
  assign tok_done_o = (state_q == usb_enc_pkg::ST_DONE) && (kind_q == usb_pid_pkg::KIND_TOK);
  assign trn_done_o = (state_q == usb_enc_pkg::ST_DONE) && (kind_q == usb_pid_pkg::KIND_DATA);
  assign enc_busy_o = (state_q != usb_enc_pkg::ST_IDLE);

  a_tx_stable: assert property (@(posedge clock) disable iff (reset)
    tx_tvalid_o && !tx_tready_i |=>
      tx_tvalid_o && $stable(tx_tdata_o) && $stable(tx_tlast_o));

  // Final byte taken, then exactly one requester sees its done pulse
  a_done_after_last: assert property (@(posedge clock) disable iff (reset)
    tx_tvalid_o && tx_tready_i && tx_tlast_o |=>
      $onehot({hsk_done_o, tok_done_o, trn_done_o}));

endmodule

// File: src/encode_packet.sv
`timescale 1ns/10ps

module encode_packet (
  input  logic        clock,
  input  logic        reset,
  output logic        enc_busy_o,
  output logic        tx_tvalid_o,
  input  logic        tx_tready_i,
  output logic        tx_tlast_o,
  output logic [7:0]  tx_tdata_o,
  input  logic        hsk_send_i,
  input  logic [1:0]  hsk_type_i,
  output logic        hsk_done_o,
  input  logic        tok_send_i,
  input  logic [1:0]  tok_type_i,
  input  logic [15:0] tok_data_i,
  output logic        tok_done_o,
  input  logic        trn_send_i,
  input  logic [1:0]  trn_type_i,
  output logic        trn_done_o,
  input  logic        trn_tvalid_i,
  output logic        trn_tready_o,
  input  logic        trn_tlast_i,
  input  logic [7:0]  trn_tdata_i
);

  logic                          body_en;
  logic                          skid_pop;
  logic                          skid_valid;
  logic                          skid_last;
  logic [7:0]                    skid_data;
  logic                          payload_accept;
  logic                          crc_clear;
  logic [15:0]                   crc_value;
  logic                          cnt_load;
  logic [usb_enc_pkg::CNT_W-1:0] cnt_value;
  logic                          cnt_zero;

  encode_fsm u_fsm (
    .clock        (clock),
    .reset        (reset),
    .hsk_send_i   (hsk_send_i),
    .hsk_type_i   (hsk_type_i),
    .tok_send_i   (tok_send_i),
    .tok_type_i   (tok_type_i),
    .tok_data_i   (tok_data_i),
    .trn_send_i   (trn_send_i),
    .trn_type_i   (trn_type_i),
    .trn_tvalid_i (trn_tvalid_i),
    .trn_tlast_i  (trn_tlast_i),
    .skid_valid_i (skid_valid),
    .skid_last_i  (skid_last),
    .skid_data_i  (skid_data),
    .crc_value_i  (crc_value),
    .cnt_zero_i   (cnt_zero),
    .tx_tready_i  (tx_tready_i),
    .body_en_o    (body_en),
    .skid_pop_o   (skid_pop),
    .crc_clear_o  (crc_clear),
    .cnt_load_o   (cnt_load),
    .cnt_value_o  (cnt_value),
    .tx_tvalid_o  (tx_tvalid_o),
    .tx_tlast_o   (tx_tlast_o),
    .tx_tdata_o   (tx_tdata_o),
    .hsk_done_o   (hsk_done_o),
    .tok_done_o   (tok_done_o),
    .trn_done_o   (trn_done_o),
    .enc_busy_o   (enc_busy_o)
  );

  // One step per accepted output byte
  tx_byte_counter u_counter (
    .clock   (clock),
    .reset   (reset),
    .load_i  (cnt_load),
    .value_i (cnt_value),
    .step_i  (tx_tvalid_o && tx_tready_i),
    .zero_o  (cnt_zero)
  );

  crc16_unit u_crc (
    .clock        (clock),
    .reset        (reset),
    .clear_i      (crc_clear),
    .byte_valid_i (payload_accept),
    .byte_i       (trn_tdata_i),
    .crc_o        (crc_value)
  );

  payload_skid u_skid (
    .clock       (clock),
    .reset       (reset),
    .enable_i    (body_en),
    .in_valid_i  (trn_tvalid_i),
    .in_last_i   (trn_tlast_i),
    .in_data_i   (trn_tdata_i),
    .pop_i       (skid_pop),
    .in_ready_o  (trn_tready_o),
    .out_valid_o (skid_valid),
    .out_last_o  (skid_last),
    .out_data_o  (skid_data),
    .accept_o    (payload_accept)
  );

endmodule

// File: test/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
  output logic clock_o,
  output logic reset_o
);

  // 4 ns period
  initial begin
    clock_o = 1'b0;
    forever #2 clock_o = ~clock_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (2) @(posedge clock_o);
    reset_o <= 1'b0;
  end

endmodule

// File: test/tb_encode_packet.sv
`timescale 1ns/10ps

module tb_encode_packet;

  localparam int MAX_REC   = 32;
  localparam int MAX_BYTES = 16;

  logic        clock;
  logic        reset;
  logic        enc_busy_o;
  logic        tx_tvalid_o;
  logic        tx_tready_i;
  logic        tx_tlast_o;
  logic [7:0]  tx_tdata_o;
  logic        hsk_send_i;
  logic [1:0]  hsk_type_i;
  logic        hsk_done_o;
  logic        tok_send_i;
  logic [1:0]  tok_type_i;
  logic [15:0] tok_data_i;
  logic        tok_done_o;
  logic        trn_send_i;
  logic [1:0]  trn_type_i;
  logic        trn_done_o;
  logic        trn_tvalid_i;
  logic        trn_tready_o;
  logic        trn_tlast_i;
  logic [7:0]  trn_tdata_i;

  int         rec_cnt;
  int         max_len;
  int         limit_cycles;
  int         errors;
  int         rx_idx;
  int         cur;
  int         rec_kind [MAX_REC];
  int         rec_type [MAX_REC];
  int         rec_tok  [MAX_REC];
  int         rec_npay [MAX_REC];
  int         rec_nexp [MAX_REC];
  logic [7:0] rec_pay  [MAX_REC][MAX_BYTES];
  logic [7:0] rec_exp  [MAX_REC][MAX_BYTES];
  logic [7:0] pay_q[$];
  int         done_q[$];
  logic       pay_fire;
  logic       zero_len;
  logic       pkt_start;
  logic       stall_q;
  logic [7:0] stall_data;
  logic       stall_last;
  logic       last_fire_q;
  logic       done_seen_q;

  clock_gen u_clock_gen (
    .clock_o (clock),
    .reset_o (reset)
  );

  encode_packet DUT (.*);

  // Hex tokens, lines starting with # are skipped
  task automatic read_hex(input int fd, output int value, output bit ok);
    string tok;
    string junk;
    int    r;
    ok = 1'b0;
    value = 0;
    forever begin
      r = $fscanf(fd, "%s", tok);
      if (r != 1) return;
      if (tok.getc(0) == "#") begin
        r = $fgets(junk, fd);
      end else begin
        value = tok.atohex();
        ok = 1'b1;
        return;
      end
    end
  endtask

  task automatic load_stim();
    int fd;
    int v;
    bit ok;
    fd = $fopen("test/encode_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file test/encode_stim.txt");
      errors++;
      return;
    end
    forever begin
      read_hex(fd, v, ok);
      if (!ok || rec_cnt >= MAX_REC) break;
      rec_kind[rec_cnt] = v;
      read_hex(fd, rec_type[rec_cnt], ok);
      read_hex(fd, rec_tok[rec_cnt], ok);
      read_hex(fd, rec_npay[rec_cnt], ok);
      for (int i = 0; i < rec_npay[rec_cnt]; i++) begin
        read_hex(fd, v, ok);
        rec_pay[rec_cnt][i] = v[7:0];
      end
      read_hex(fd, rec_nexp[rec_cnt], ok);
      for (int i = 0; i < rec_nexp[rec_cnt]; i++) begin
        read_hex(fd, v, ok);
        rec_exp[rec_cnt][i] = v[7:0];
      end
      if (rec_nexp[rec_cnt] > max_len) max_len = rec_nexp[rec_cnt];
      rec_cnt++;
    end
    $fclose(fd);
  endtask

  task automatic run_record(input int r);
    int want[$];
    cur = r;
    rx_idx = 0;
    pkt_start = 1'b1;
    done_q.delete();
    pay_q.delete();
    for (int i = 0; i < rec_npay[r]; i++) pay_q.push_back(rec_pay[r][i]);
    zero_len = (rec_kind[r] == 2) && (rec_npay[r] == 0);
    // Kind 3 raises handshake and data together, handshake must finish first
    case (rec_kind[r])
      0: want = '{0};
      1: want = '{1};
      2: want = '{2};
      default: want = '{0, 2};
    endcase
    @(negedge clock);
    hsk_type_i = (rec_kind[r] == 3) ? rec_type[r][3:2] : rec_type[r][1:0];
    tok_type_i = rec_type[r][1:0];
    trn_type_i = rec_type[r][1:0];
    tok_data_i = rec_tok[r][15:0];
    hsk_send_i = (rec_kind[r] == 0) || (rec_kind[r] == 3);
    tok_send_i = (rec_kind[r] == 1);
    trn_send_i = (rec_kind[r] == 2) || (rec_kind[r] == 3);
    while (done_q.size() < want.size()) @(negedge clock);
    hsk_send_i = 1'b0;
    tok_send_i = 1'b0;
    trn_send_i = 1'b0;
    zero_len = 1'b0;
    @(negedge clock);
    if (rx_idx != rec_nexp[r]) begin
      $display("Record %0d sent %0d bytes instead of %0d", r, rx_idx, rec_nexp[r]);
      errors++;
    end
    if (done_q.size() != want.size()) begin
      $display("Record %0d gave %0d done pulses instead of %0d", r, done_q.size(), want.size());
      errors++;
    end else begin
      foreach (want[i]) begin
        if (done_q[i] != want[i]) begin
          $display("Record %0d finished its requests in the wrong order", r);
          errors++;
        end
      end
    end
    @(negedge clock);
  endtask

  // Output monitor
  always @(posedge clock) begin
    usb_pid_pkg::pid_byte_u pid_chk;
    logic exp_last;
    logic done_any;
    if (reset) begin
      pay_fire    <= 1'b0;
      stall_q     <= 1'b0;
      last_fire_q <= 1'b0;
      done_seen_q <= 1'b0;
    end else begin
      pay_fire <= trn_tvalid_i && trn_tready_o;
      if (stall_q && !tx_tvalid_o) begin
        $display("At %0t the output dropped valid before the byte was taken", $time);
        errors++;
      end else if (stall_q && (tx_tdata_o !== stall_data || tx_tlast_o !== stall_last)) begin
        $display("ERR %0t tx_tdata_o/tx_tlast_o exp %h/%b got %h/%b", $time,
                 stall_data, stall_last, tx_tdata_o, tx_tlast_o);
        errors++;
      end
      stall_q    <= tx_tvalid_o && !tx_tready_i;
      stall_data <= tx_tdata_o;
      stall_last <= tx_tlast_o;
      if (tx_tvalid_o && tx_tready_i) begin
        if (rx_idx >= rec_nexp[cur]) begin
          $display("At %0t record %0d sent an extra byte %h", $time, cur, tx_tdata_o);
          errors++;
        end else begin
          exp_last = (rx_idx == rec_nexp[cur] - 1) || (rec_kind[cur] == 3 && rx_idx == 0);
          if (tx_tdata_o !== rec_exp[cur][rx_idx]) begin
            $display("ERR %0t tx_tdata_o exp %h got %h", $time, rec_exp[cur][rx_idx], tx_tdata_o);
            errors++;
          end
          if (tx_tlast_o !== exp_last) begin
            $display("ERR %0t tx_tlast_o exp %b got %b", $time, exp_last, tx_tlast_o);
            errors++;
          end
        end
        if (pkt_start) begin
          pid_chk.raw = tx_tdata_o;
          if (pid_chk.nib.check !== ~pid_chk.nib.code) begin
            $display("ERR %0t pid check exp %h got %h", $time, ~pid_chk.nib.code,
                     pid_chk.nib.check);
            errors++;
          end
        end
        pkt_start = tx_tlast_o;
        rx_idx++;
      end

      // Done pulses follow the final byte by one cycle, busy spans the packet
      done_any = hsk_done_o || tok_done_o || trn_done_o;
      if (done_any !== last_fire_q) begin
        $display("ERR %0t done outputs exp %b got %b", $time, last_fire_q, done_any);
        errors++;
      end
      if ((tx_tvalid_o || done_any) && enc_busy_o !== 1'b1) begin
        $display("ERR %0t enc_busy_o exp 1 got %b", $time, enc_busy_o);
        errors++;
      end
      if (done_seen_q && enc_busy_o !== 1'b0) begin
        $display("ERR %0t enc_busy_o exp 0 got %b", $time, enc_busy_o);
        errors++;
      end
      if (!enc_busy_o && trn_tready_o !== 1'b0) begin
        $display("ERR %0t trn_tready_o exp 0 got %b", $time, trn_tready_o);
        errors++;
      end
      last_fire_q <= tx_tvalid_o && tx_tready_i && tx_tlast_o;
      done_seen_q <= done_any;

      if (hsk_done_o) done_q.push_back(0);
      if (tok_done_o) done_q.push_back(1);
      if (trn_done_o) done_q.push_back(2);
    end
  end

  // Payload source with random gaps and random output back-pressure
  always @(negedge clock) begin
    tx_tready_i = ($urandom_range(3) != 0);
    if (pay_fire && pay_q.size() > 0) void'(pay_q.pop_front());
    if (pay_q.size() == 0) begin
      trn_tvalid_i = 1'b0;
      trn_tlast_i  = zero_len;
      trn_tdata_i  = 8'h00;
    end else if (!trn_tvalid_i || pay_fire) begin
      trn_tvalid_i = ($urandom_range(3) != 0);
      trn_tlast_i  = trn_tvalid_i && (pay_q.size() == 1);
      trn_tdata_i  = pay_q[0];
    end
  end

  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clock);
    $display("Timeout after %0d cycles, the encoder is stuck", limit_cycles);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    void'($urandom(9));
    hsk_send_i   = 1'b0;
    hsk_type_i   = 2'b00;
    tok_send_i   = 1'b0;
    tok_type_i   = 2'b00;
    tok_data_i   = 16'h0000;
    trn_send_i   = 1'b0;
    trn_type_i   = 2'b00;
    trn_tvalid_i = 1'b0;
    trn_tlast_i  = 1'b0;
    trn_tdata_i  = 8'h00;
    tx_tready_i  = 1'b0;
    zero_len     = 1'b0;
    pkt_start    = 1'b1;
    errors       = 0;
    rec_cnt      = 0;
    max_len      = 1;
    cur          = 0;
    rx_idx       = 0;
    load_stim();
    limit_cycles = rec_cnt * max_len * 20 + 20;
    @(negedge clock);
    while (reset) @(negedge clock);
    for (int r = 0; r < rec_cnt; r++) run_record(r);
    $display("Records %0d, errors %0d", rec_cnt, errors);
    if (errors == 0 && rec_cnt > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: test/encode_stim.txt
# kind type tok npay payload... nexp expected... (all hex)
# kind 0 hsk, 1 token, 2 data, 3 hsk with data (type bits 3:2 hsk, 1:0 data)
0 0 0000 0 1 D2
0 2 0000 0 1 5A
0 3 0000 0 1 1E
1 2 1A81 0 3 69 81 1A
1 3 E800 0 3 2D 00 E8
1 1 B07F 0 3 A5 7F B0
1 0 0123 0 3 E1 23 01
2 0 0000 1 00 4 C3 00 40 BF
2 2 0000 1 01 4 4B 01 81 7F
2 1 0000 2 00 00 5 87 00 00 FE 4F
2 3 0000 4 00 01 02 03 7 0F 00 01 02 03 EF 7A
2 0 0000 5 00 01 02 03 00 8 C3 00 01 02 03 00 7B 33
2 2 0000 0 3 4B 00 00
2 0 0000 0 3 C3 00 00
3 E 0000 4 00 01 02 03 8 1E 4B 00 01 02 03 EF 7A
3 0 0000 1 01 5 D2 C3 01 81 7F
0 2 0000 0 1 5A
2 3 0000 2 00 00 5 0F 00 00 FE 4F

// File: sources.f
src/usb_pid_pkg.sv
src/usb_enc_pkg.sv
src/tx_byte_counter.sv
src/crc16_unit.sv
src/payload_skid.sv
src/encode_fsm.sv
src/encode_packet.sv
test/clock_gen.sv
test/tb_encode_packet.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_encode_packet
RTL_TOP   ?= encode_packet
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
